/* design/muldiv_consts.svh */
//------------------
// Widths, opcode fields and divider step count for the multiply/divide
// unit. Include it wherever one of these macros is used.
//------------------
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Data and register index widths
`define MULDIV_XLEN       32
`define MULDIV_REG_IDX_W  5

// R-type integer major opcode
`define MULDIV_OPCODE_OP  7'b0110011

// funct7 of the M extension
`define MULDIV_FUNCT7_M   7'b0000001

// One quotient bit per step
`define MULDIV_DIV_STEPS  32

`endif

/* design/muldiv_pkg.sv */
//------------------
// Types shared by the multiply/divide unit: data words, operation
// encodings and the request and result structs between stages.
//------------------
`include "muldiv_consts.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0]      word_t;
    typedef logic [`MULDIV_REG_IDX_W-1:0] reg_idx_t;

    // funct3 encodings of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    typedef struct packed {
        logic       valid;
        muldiv_op_e op;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
    } mul_req_t;

    typedef struct packed {
        logic       valid;
        muldiv_op_e op;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
    } div_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } result_t;

endpackage

/* design/muldiv_decode.sv */
//------------------
// Decode stage. Picks M-extension ops out of the incoming R-type
// instruction and registers a request for the multiplier or divider.
//------------------
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module muldiv_decode
    import muldiv_pkg::*;
(
     input  logic     clk_i
    ,input  logic     rst_n_i
    ,input  logic     opcode_valid_i
    ,input  word_t    opcode_i
    ,input  word_t    ra_operand_i
    ,input  word_t    rb_operand_i
    ,input  logic     div_busy_i
    ,output logic     busy_o
    ,output mul_req_t mul_req_o
    ,output div_req_t div_req_o
);

logic [2:0] funct3;
logic       is_m_op;
logic       accept;

always_comb begin
    funct3  = opcode_i[14:12];
    is_m_op = (opcode_i[6:0] == `MULDIV_OPCODE_OP) && (opcode_i[31:25] == `MULDIV_FUNCT7_M);
    accept  = opcode_valid_i && is_m_op && !busy_o;
end

// Busy covers the cycle before the divider leaves idle
assign busy_o = div_busy_i || div_req_o.valid;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mul_req_o <= '0;
        div_req_o <= '0;
    end else begin
        // funct3[2] splits multiplies from divides
        mul_req_o.valid <= accept && !funct3[2];
        mul_req_o.op    <= muldiv_op_e'(funct3);
        mul_req_o.rd    <= opcode_i[11:7];
        mul_req_o.a     <= ra_operand_i;
        mul_req_o.b     <= rb_operand_i;

        div_req_o.valid <= accept && funct3[2];
        div_req_o.op    <= muldiv_op_e'(funct3);
        div_req_o.rd    <= opcode_i[11:7];
        div_req_o.a     <= ra_operand_i;
        div_req_o.b     <= rb_operand_i;
    end
end

endmodule

/* design/muldiv_multiplier.sv */
//------------------
// Two-stage pipelined multiplier for MUL, MULH, MULHSU and MULHU.
// Takes a new request every cycle, result two cycles later.
//------------------
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module muldiv_multiplier
    import muldiv_pkg::*;
(
     input  logic     clk_i
    ,input  logic     rst_n_i
    ,input  mul_req_t mul_req_i
    ,output result_t  mul_res_o
);

logic                           a_signed;
logic                           b_signed;
logic signed [`MULDIV_XLEN:0]   a_ext;
logic signed [`MULDIV_XLEN:0]   b_ext;
logic signed [2*`MULDIV_XLEN-1:0] product;

logic                           s1_valid_q;
logic                           s1_high_q;
reg_idx_t                       s1_rd_q;
logic [2*`MULDIV_XLEN-1:0]      s1_prod_q;

//------------------
// Stage 1
//------------------
always_comb begin
    a_signed = (mul_req_i.op == OP_MULH) || (mul_req_i.op == OP_MULHSU);
    b_signed = (mul_req_i.op == OP_MULH);
    a_ext    = {a_signed && mul_req_i.a[`MULDIV_XLEN-1], mul_req_i.a};
    b_ext    = {b_signed && mul_req_i.b[`MULDIV_XLEN-1], mul_req_i.b};
    // 33x33 signed covers every sign mix, low 64 bits kept
    product  = a_ext * b_ext;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        s1_valid_q <= 1'b0;
        s1_high_q  <= 1'b0;
        s1_rd_q    <= '0;
        s1_prod_q  <= '0;
    end else begin
        s1_valid_q <= mul_req_i.valid;
        s1_high_q  <= (mul_req_i.op != OP_MUL);
        s1_rd_q    <= mul_req_i.rd;
        s1_prod_q  <= product;
    end
end

//------------------
// Stage 2
//------------------
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mul_res_o <= '0;
    end else begin
        mul_res_o.valid <= s1_valid_q;
        mul_res_o.rd    <= s1_rd_q;
        if (s1_high_q) begin
            mul_res_o.value <= s1_prod_q[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
        end else begin
            mul_res_o.value <= s1_prod_q[`MULDIV_XLEN-1:0];
        end
    end
end

endmodule

/* design/muldiv_divider.sv */
//------------------
// Iterative radix-2 restoring divider for DIV, DIVU, REM and REMU.
// Divide by zero and signed overflow finish without iterating. The
// result is held in DIV_DONE until writeback takes it.
//------------------
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module muldiv_divider
    import muldiv_pkg::*;
(
     input  logic     clk_i
    ,input  logic     rst_n_i
    ,input  div_req_t div_req_i
    ,input  logic     div_taken_i
    ,output logic     div_busy_o
    ,output result_t  div_res_o
);

localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS);

div_state_e             state_q;
logic [CNT_W-1:0]       cnt_q;
reg_idx_t               rd_q;
logic                   want_rem_q;
logic                   neg_quot_q;
logic                   neg_rem_q;
word_t                  quot_q;
word_t                  rem_q;
word_t                  dvsr_q;
word_t                  result_q;

logic                   signed_op;
logic                   want_rem;
logic                   a_neg;
logic                   b_neg;
word_t                  a_mag;
word_t                  b_mag;
logic                   div_zero;
logic                   overflow;
logic                   start;
logic                   last_step;
logic [`MULDIV_XLEN:0]  rem_shift;
logic [`MULDIV_XLEN:0]  rem_diff;
word_t                  quot_next;
word_t                  rem_next;

always_comb begin
    signed_op = (div_req_i.op == OP_DIV) || (div_req_i.op == OP_REM);
    want_rem  = (div_req_i.op == OP_REM) || (div_req_i.op == OP_REMU);
    a_neg     = signed_op && div_req_i.a[`MULDIV_XLEN-1];
    b_neg     = signed_op && div_req_i.b[`MULDIV_XLEN-1];
    a_mag     = a_neg ? -div_req_i.a : div_req_i.a;
    b_mag     = b_neg ? -div_req_i.b : div_req_i.b;
    div_zero  = (div_req_i.b == '0);
    overflow  = signed_op && (div_req_i.a == {1'b1, {(`MULDIV_XLEN-1){1'b0}}})
                && (&div_req_i.b);
    start     = (state_q == DIV_IDLE) && div_req_i.valid;
    last_step = (cnt_q == CNT_W'(`MULDIV_DIV_STEPS - 1));

    // Shift one dividend bit into the partial remainder
    rem_shift = {rem_q, quot_q[`MULDIV_XLEN-1]};
    rem_diff  = rem_shift - {1'b0, dvsr_q};
    if (rem_diff[`MULDIV_XLEN]) begin
        rem_next  = rem_shift[`MULDIV_XLEN-1:0];
        quot_next = {quot_q[`MULDIV_XLEN-2:0], 1'b0};
    end else begin
        rem_next  = rem_diff[`MULDIV_XLEN-1:0];
        quot_next = {quot_q[`MULDIV_XLEN-2:0], 1'b1};
    end
end

//------------------
// FSM
//------------------
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= DIV_IDLE;
    end else begin
        case (state_q)
            DIV_IDLE: begin
                if (div_req_i.valid) begin
                    state_q <= (div_zero || overflow) ? DIV_DONE : DIV_RUN;
                end
            end
            DIV_RUN: begin
                if (last_step) begin
                    state_q <= DIV_DONE;
                end
            end
            DIV_DONE: begin
                if (div_taken_i) begin
                    state_q <= DIV_IDLE;
                end
            end
            default: state_q <= DIV_IDLE;
        endcase
    end
end

//------------------
// Datapath
//------------------
always_ff @(posedge clk_i) begin
    if (start) begin
        rd_q       <= div_req_i.rd;
        want_rem_q <= want_rem;
        neg_quot_q <= a_neg ^ b_neg;
        neg_rem_q  <= a_neg;
        quot_q     <= a_mag;
        rem_q      <= '0;
        dvsr_q     <= b_mag;
        cnt_q      <= '0;
        // Only the early-exit cases use this value
        if (div_zero) begin
            result_q <= want_rem ? div_req_i.a : '1;
        end else begin
            result_q <= want_rem ? '0 : div_req_i.a;
        end
    end else if (state_q == DIV_RUN) begin
        quot_q <= quot_next;
        rem_q  <= rem_next;
        cnt_q  <= cnt_q + 1'b1;
        // Sign fix, final on the last step
        if (want_rem_q) begin
            result_q <= neg_rem_q ? -rem_next : rem_next;
        end else begin
            result_q <= neg_quot_q ? -quot_next : quot_next;
        end
    end
end

assign div_busy_o      = (state_q != DIV_IDLE);
assign div_res_o.valid = (state_q == DIV_DONE);
assign div_res_o.rd    = rd_q;
assign div_res_o.value = result_q;

endmodule

/* design/muldiv_writeback.sv */
//------------------
// Writeback stage. Merges multiplier and divider results into one
// registered writeback port. The multiplier always wins, the divider
// holds its result until taken.
//------------------
`timescale 1ns/1ns

module muldiv_writeback
    import muldiv_pkg::*;
(
     input  logic    clk_i
    ,input  logic    rst_n_i
    ,input  result_t mul_res_i
    ,input  result_t div_res_i
    ,output logic    div_taken_o
    ,output result_t wb_o
);

result_t sel;

always_comb begin
    // Multiplier has no stall path
    if (mul_res_i.valid) begin
        sel = mul_res_i;
    end else begin
        sel = div_res_i;
    end
    div_taken_o = div_res_i.valid && !mul_res_i.valid;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wb_o <= '0;
    end else begin
        wb_o <= sel;
    end
end

endmodule

/* design/muldiv_unit.sv */
//------------------
// Multiply/divide execution unit. One decoded R-type instruction per
// strobe in, one tagged writeback pulse per M-extension result out.
// Do not strobe while busy_o is high.
//------------------
`timescale 1ns/1ns

module muldiv_unit
    import muldiv_pkg::*;
(
     input  logic     clk_i
    ,input  logic     rst_n_i
    ,input  logic     opcode_valid_i
    ,input  word_t    opcode_i
    ,input  word_t    ra_operand_i
    ,input  word_t    rb_operand_i
    ,output logic     busy_o
    ,output logic     writeback_valid_o
    ,output reg_idx_t writeback_rd_idx_o
    ,output word_t    writeback_value_o
);

mul_req_t mul_req;
div_req_t div_req;
result_t  mul_res;
result_t  div_res;
result_t  wb;
logic     div_busy;
logic     div_taken;

muldiv_decode
u_decode
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.opcode_valid_i(opcode_valid_i)
    ,.opcode_i(opcode_i)
    ,.ra_operand_i(ra_operand_i)
    ,.rb_operand_i(rb_operand_i)
    ,.div_busy_i(div_busy)
    ,.busy_o(busy_o)
    ,.mul_req_o(mul_req)
    ,.div_req_o(div_req)
);

muldiv_multiplier
u_mul
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.mul_req_i(mul_req)
    ,.mul_res_o(mul_res)
);

muldiv_divider
u_div
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.div_req_i(div_req)
    ,.div_taken_i(div_taken)
    ,.div_busy_o(div_busy)
    ,.div_res_o(div_res)
);

muldiv_writeback
u_wb
(
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.mul_res_i(mul_res)
    ,.div_res_i(div_res)
    ,.div_taken_o(div_taken)
    ,.wb_o(wb)
);

assign writeback_valid_o  = wb.valid;
assign writeback_rd_idx_o = wb.rd;
assign writeback_value_o  = wb.value;

endmodule

/* bench/muldiv_unit_asserts.sv */
//------------------
// Concurrent checks for the multiply/divide unit. Bound to the top
// level; results are compared with the head of the bench's queue.
//------------------
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module muldiv_unit_asserts
    import muldiv_pkg::*;
(
     input logic     clk_i
    ,input logic     rst_n_i
    ,input logic     opcode_valid_i
    ,input word_t    opcode_i
    ,input logic     busy_o
    ,input logic     writeback_valid_o
    ,input reg_idx_t writeback_rd_idx_o
    ,input word_t    writeback_value_o
    ,input logic     exp_pending_i
    ,input reg_idx_t exp_rd_i
    ,input word_t    exp_value_i
);

int unsigned error_count = 0;

logic       is_m_op;
logic       mul_accept;
logic       div_accept;
logic [3:0] mul_pipe_q;
logic       div_accept_q;

always_comb begin
    is_m_op    = (opcode_i[6:0] == `MULDIV_OPCODE_OP) && (opcode_i[31:25] == `MULDIV_FUNCT7_M);
    mul_accept = opcode_valid_i && is_m_op && !busy_o && !opcode_i[14];
    div_accept = opcode_valid_i && is_m_op && !busy_o && opcode_i[14];
end

// Accept history for the timing checks
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mul_pipe_q   <= '0;
        div_accept_q <= 1'b0;
    end else begin
        mul_pipe_q   <= {mul_pipe_q[2:0], mul_accept};
        div_accept_q <= div_accept;
    end
end

//------------------
// Results
//------------------
wb_expected_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    writeback_valid_o |-> exp_pending_i)
else begin
    error_count++;
    $error("Writeback pulse with no operation outstanding");
end

wb_rd_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    writeback_valid_o |-> (writeback_rd_idx_o == exp_rd_i))
else begin
    error_count++;
    $error("[ERROR] writeback_rd_idx_o got %h, expected %h",
           $sampled(writeback_rd_idx_o), $sampled(exp_rd_i));
end

wb_value_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    writeback_valid_o |-> (writeback_value_o == exp_value_i))
else begin
    error_count++;
    $error("[ERROR] writeback_value_o got %h, expected %h",
           $sampled(writeback_value_o), $sampled(exp_value_i));
end

//------------------
// Timing
//------------------
mul_latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_pipe_q[3] |-> writeback_valid_o)
else begin
    error_count++;
    $error("Multiply result missing in the cycle after edge N+3");
end

busy_rise_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    div_accept_q |-> busy_o)
else begin
    error_count++;
    $error("busy_o did not rise after a divide was accepted");
end

busy_cause_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(busy_o) |-> div_accept_q)
else begin
    error_count++;
    $error("busy_o rose without an accepted divide");
end

busy_release_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(busy_o) |-> writeback_valid_o)
else begin
    error_count++;
    $error("busy_o fell without the divide result being written back");
end

reset_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |-> (!writeback_valid_o && !busy_o))
else begin
    error_count++;
    $error("Writeback or busy active during reset");
end

endmodule

/* bench/muldiv_unit_tb.sv */
//------------------
// Testbench for the multiply/divide unit. Issues random and corner
// case M-extension ops, keeps the expected results in a queue whose
// head feeds the bound assertions, and prints the verdict.
//------------------
`timescale 1ns/1ns
`include "muldiv_consts.svh"

module muldiv_unit_tb
    import muldiv_pkg::*;
();

localparam int CLK_PERIOD  = 4;
localparam int DRIVE_DELAY = 1;

typedef struct packed {
    reg_idx_t rd;
    word_t    value;
} expect_t;

logic     clk_i;
logic     rst_n_i;
logic     opcode_valid_i;
word_t    opcode_i;
word_t    ra_operand_i;
word_t    rb_operand_i;
logic     busy_o;
logic     writeback_valid_o;
reg_idx_t writeback_rd_idx_o;
word_t    writeback_value_o;

// Queue head as seen by the assertions
logic     exp_pending;
reg_idx_t exp_rd;
word_t    exp_value;
expect_t  exp_q[$];
logic     pop_due;
int       seed;

muldiv_unit muldiv_unit_inst (.*);

bind muldiv_unit muldiv_unit_asserts asserts_inst (
     .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.opcode_valid_i(opcode_valid_i)
    ,.opcode_i(opcode_i)
    ,.busy_o(busy_o)
    ,.writeback_valid_o(writeback_valid_o)
    ,.writeback_rd_idx_o(writeback_rd_idx_o)
    ,.writeback_value_o(writeback_value_o)
    ,.exp_pending_i(muldiv_unit_tb.exp_pending)
    ,.exp_rd_i(muldiv_unit_tb.exp_rd)
    ,.exp_value_i(muldiv_unit_tb.exp_value)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

//------------------
// RISC-V M-extension model
//------------------
function automatic word_t expected_result(input muldiv_op_e op, input word_t a, input word_t b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] prod;
    int          sdiv_a;
    int          sdiv_b;
    logic        overflow;
    sa       = {{32{a[31]}}, a};
    sb       = {{32{b[31]}}, b};
    ua       = {32'd0, a};
    ub       = {32'd0, b};
    sdiv_a   = a;
    sdiv_b   = b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        OP_MUL:    prod = ua * ub;
        OP_MULH:   prod = sa * sb;
        OP_MULHSU: prod = sa * ub;
        OP_MULHU:  prod = ua * ub;
        default:   prod = '0;
    endcase
    case (op)
        OP_MUL:  return prod[31:0];
        OP_DIV:  return (b == 0) ? '1 : (overflow ? a : word_t'(sdiv_a / sdiv_b));
        OP_DIVU: return (b == 0) ? '1 : a / b;
        OP_REM:  return (b == 0) ? a : (overflow ? '0 : word_t'(sdiv_a % sdiv_b));
        OP_REMU: return (b == 0) ? a : a % b;
        default: return prod[63:32];
    endcase
endfunction

task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
endtask

task automatic step();
    @(posedge clk_i);
    #DRIVE_DELAY;
endtask

task automatic refresh_head();
    exp_pending = (exp_q.size() != 0);
    exp_rd      = exp_pending ? exp_q[0].rd : '0;
    exp_value   = exp_pending ? exp_q[0].value : '0;
endtask

task automatic drive_insn(input word_t insn, input word_t a, input word_t b);
    opcode_valid_i = 1'b1;
    opcode_i       = insn;
    ra_operand_i   = a;
    rb_operand_i   = b;
endtask

task automatic issue_op(input muldiv_op_e op, input reg_idx_t rd,
                        input word_t a, input word_t b);
    expect_t item;
    drive_insn({`MULDIV_FUNCT7_M, 10'd0, op, rd, `MULDIV_OPCODE_OP}, a, b);
    item.rd    = rd;
    item.value = expected_result(op, a, b);
    exp_q.push_back(item);
    refresh_head();
    step();
endtask

task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || busy_o) begin
        if (cycles >= limit) begin
            stop_with_failure("Timeout waiting for outstanding results");
        end else begin
            step();
            cycles++;
        end
    end
endtask

// Retire the head one negedge after the edge that checked it
always @(negedge clk_i) begin
    if (muldiv_unit_inst.asserts_inst.error_count != 0) begin
        stop_with_failure("A DUT assertion failed");
    end else begin
        if (pop_due && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
        pop_due = writeback_valid_o;
    end
end

initial begin
    seed           = 32'ha170_b5f2;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    opcode_valid_i = 1'b0;
    opcode_i       = '0;
    ra_operand_i   = '0;
    rb_operand_i   = '0;
    pop_due        = 1'b0;
    refresh_head();
    repeat (2) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    step();

    // ADD and XOR must give no writeback and no busy
    drive_insn({7'd0, 10'd0, 3'b000, 5'd3, `MULDIV_OPCODE_OP}, 32'd5, 32'd7);
    step();
    drive_insn({7'd0, 10'd0, 3'b100, 5'd4, `MULDIV_OPCODE_OP}, 32'd5, 32'd7);
    step();
    opcode_valid_i = 1'b0;
    repeat (8) step();

    for (int i = 0; i < 16; i++) begin
        issue_op(muldiv_op_e'({1'b0, i[1:0]}), reg_idx_t'($random(seed)),
                 $random(seed), $random(seed));
        opcode_valid_i = 1'b0;
        wait_drain(10);
    end

    // Back-to-back multiplies
    for (int i = 0; i < 8; i++) begin
        issue_op(muldiv_op_e'({1'b0, i[1:0]}), reg_idx_t'(i), $random(seed), $random(seed));
    end
    opcode_valid_i = 1'b0;
    wait_drain(20);

    for (int i = 0; i < 24; i++) begin
        word_t divisor;
        divisor = word_t'($random(seed) >>> ($unsigned($random(seed)) % 30));
        issue_op(muldiv_op_e'({1'b1, i[1:0]}), reg_idx_t'($random(seed)),
                 $random(seed), divisor);
        opcode_valid_i = 1'b0;
        wait_drain(50);
    end

    // Divide by zero and signed overflow
    for (int i = 0; i < 4; i++) begin
        issue_op(muldiv_op_e'({1'b1, i[1:0]}), 5'd10, $random(seed), '0);
        opcode_valid_i = 1'b0;
        wait_drain(10);
        issue_op(muldiv_op_e'({1'b1, i[1:0]}), 5'd11, 32'h8000_0000, 32'hffff_ffff);
        opcode_valid_i = 1'b0;
        wait_drain(50);
    end

    // Multiply then divide by zero on the next cycle
    for (int i = 0; i < 4; i++) begin
        issue_op(muldiv_op_e'({1'b0, i[1:0]}), 5'd12, $random(seed), $random(seed));
        issue_op(muldiv_op_e'({1'b1, i[1:0]}), 5'd13, $random(seed), '0);
        opcode_valid_i = 1'b0;
        wait_drain(12);
    end

    repeat (4) step();
    if (muldiv_unit_inst.asserts_inst.error_count != 0) begin
        stop_with_failure("Assertion errors were reported");
    end else begin
        $display("Result: PASSED");
        $finish;
    end
end

endmodule

/* muldiv_unit.f */
+incdir+design
design/muldiv_pkg.sv
design/muldiv_decode.sv
design/muldiv_multiplier.sv
design/muldiv_divider.sv
design/muldiv_writeback.sv
design/muldiv_unit.sv
bench/muldiv_unit_asserts.sv
bench/muldiv_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the muldiv_unit testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module muldiv_unit_tb \
    -f muldiv_unit.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vmuldiv_unit_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
